// File: build.f
common/rv_isa_pkg.sv
common/pipe_pkg.sv
rtl/decode/insn_decoder.sv
rtl/decode/reg_file.sv
rtl/decode/decode_stage.sv
rtl/fetch_stage.sv
rtl/execute_stage.sv
rtl/retire_stage.sv
rtl/riscv_pipeline.sv
sim/tb_riscv_pipeline.sv

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  import rv_isa_pkg::*;

  // what occupies writeback in a given cycle
  typedef enum logic [2:0] {
    CYCLE_INVALID      = 3'd0,
    CYCLE_RESET        = 3'd1,
    CYCLE_NO_STALL     = 3'd2,
    CYCLE_TAKEN_BRANCH = 3'd4
  } cycle_status_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
  } decode_entry_t;

  typedef struct packed {
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  reg_we;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_halt;
    logic [FUNCT3_W-1:0]   branch_f3;
    word_t                 imm;
  } ctrl_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    reg_addr_t     rs1;
    reg_addr_t     rs2;
    reg_addr_t     rd;
    word_t         rs1_data;
    word_t         rs2_data;
    ctrl_t         ctrl;
    cycle_status_e status;
  } execute_entry_t;

  // memory and writeback registers share this layout
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    reg_addr_t     rd;
    word_t         rd_data;
    logic          reg_we;
    logic          halt;
    cycle_status_e status;
  } retire_t;

  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     data;
  } reg_write_t;

endpackage

`default_nettype wire

// File: common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int PC_STEP    = 4;

  // instruction field widths
  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // only the major opcodes this core executes
  typedef enum logic [OPCODE_W-1:0] {
    OP_LUI     = 7'b0110111,
    OP_JAL     = 7'b1101111,
    OP_JALR    = 7'b1100111,
    OP_BRANCH  = 7'b1100011,
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_SYSTEM  = 7'b1110011
  } opcode_e;

  // branch conditions
  localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
  localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;
  localparam logic [FUNCT3_W-1:0] F3_JALR = 3'b000;

  // alu ops, shared by the reg-imm and reg-reg forms
  localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
  localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
  localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

  // selects SUB and SRA
  localparam logic [FUNCT7_W-1:0] FUNCT7_ALT = 7'b0100000;

endpackage

`default_nettype wire

// File: rtl/decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_isa_pkg::*, pipe_pkg::*; (
  input  wire                clk,
  input  wire                rst,
  input  wire decode_entry_t decode_entry,
  input  wire                redirect,
  input  wire reg_write_t    wb_write,
  output execute_entry_t     execute_entry
);

  reg_addr_t      rs1_idx;
  reg_addr_t      rs2_idx;
  word_t          rf_rs1;
  word_t          rf_rs2;
  ctrl_t          ctrl;
  execute_entry_t exe_q;

  // same-cycle writeback beats the stale register file value
  function automatic word_t wd_pick(input reg_addr_t idx, input word_t rf_val,
                                    input reg_write_t wb);
    if (wb.we && wb.rd == idx && idx != '0) begin
      return wb.data;
    end
    return rf_val;
  endfunction

  assign rs1_idx = decode_entry.insn[19:15];
  assign rs2_idx = decode_entry.insn[24:20];

  insn_decoder u_insn_decoder (
    .insn (decode_entry.insn),
    .ctrl (ctrl)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1_idx),
    .rs2      (rs2_idx),
    .wr       (wb_write),
    .rs1_data (rf_rs1),
    .rs2_data (rf_rs2)
  );

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      exe_q        <= '0;
      exe_q.status <= rst ? CYCLE_RESET : CYCLE_TAKEN_BRANCH;
    end else begin
      exe_q.pc       <= decode_entry.pc;
      exe_q.insn     <= decode_entry.insn;
      exe_q.rs1      <= rs1_idx;
      exe_q.rs2      <= rs2_idx;
      exe_q.rd       <= decode_entry.insn[11:7];
      exe_q.rs1_data <= wd_pick(rs1_idx, rf_rs1, wb_write);
      exe_q.rs2_data <= wd_pick(rs2_idx, rf_rs2, wb_write);
      exe_q.ctrl     <= ctrl;
      exe_q.status   <= decode_entry.status;
    end
  end

  assign execute_entry = exe_q;

endmodule

`default_nettype wire

// File: rtl/decode/insn_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decoder import rv_isa_pkg::*, pipe_pkg::*; (
  input  wire word_t insn,
  output ctrl_t      ctrl
);

  opcode_e             opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic [FUNCT7_W-1:0] funct7;
  word_t               imm_i;
  word_t               imm_b;
  word_t               imm_j;
  word_t               imm_u;
  alu_op_e             alu_sel;
  logic                is_alt;
  logic                reg_ok;
  logic                imm_ok;
  logic                branch_ok;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign is_alt = (funct7 == FUNCT7_ALT);

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // funct7 only means SUB for the register form, addi keeps it as immediate bits
  always_comb begin
    case (funct3)
      F3_ADD_SUB: alu_sel = (opcode == OP_REG_REG && is_alt) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_sel = ALU_SLL;
      F3_SLT:     alu_sel = ALU_SLT;
      F3_SLTU:    alu_sel = ALU_SLTU;
      F3_XOR:     alu_sel = ALU_XOR;
      F3_SRL_SRA: alu_sel = is_alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_sel = ALU_OR;
      default:    alu_sel = ALU_AND;
    endcase
  end

  // legal funct7 patterns per form
  assign reg_ok = (funct7 == '0) ||
                  (is_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
  assign imm_ok = (funct3 != F3_SLL && funct3 != F3_SRL_SRA) || (funct7 == '0) ||
                  (is_alt && funct3 == F3_SRL_SRA);
  assign branch_ok = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

  always_comb begin
    ctrl = '0;
    case (opcode)
      OP_LUI: begin
        ctrl.alu_op  = ALU_PASS_B;
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.imm     = imm_u;
      end
      OP_REG_IMM: begin
        ctrl.alu_op  = alu_sel;
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = imm_ok;
        ctrl.imm     = imm_i;
      end
      OP_REG_REG: begin
        ctrl.alu_op = alu_sel;
        ctrl.reg_we = reg_ok;
      end
      OP_BRANCH: begin
        ctrl.is_branch = branch_ok;
        ctrl.branch_f3 = funct3;
        ctrl.imm       = imm_b;
      end
      OP_JAL: begin
        ctrl.is_jal = 1'b1;
        ctrl.reg_we = 1'b1;
        ctrl.imm    = imm_j;
      end
      OP_JALR: begin
        ctrl.is_jalr = (funct3 == F3_JALR);
        ctrl.reg_we  = (funct3 == F3_JALR);
        ctrl.imm     = imm_i;
      end
      // ecall only, everything else in this space is ignored
      OP_SYSTEM: ctrl.is_halt = (insn[31:7] == '0);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/decode/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_isa_pkg::*, pipe_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire reg_addr_t  rs1,
  input  wire reg_addr_t  rs2,
  input  wire reg_write_t wr,
  output word_t           rs1_data,
  output word_t           rs2_data
);

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // execute must already have dropped writes to x0
  no_x0_write: assert property (@(posedge clk) disable iff (rst) !(wr.we && wr.rd == '0));

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_isa_pkg::*, pipe_pkg::*; (
  input  wire execute_entry_t execute_entry,
  input  wire retire_t        mem_entry,
  input  wire reg_write_t     wb_write,
  output logic                redirect,
  output word_t               redirect_pc,
  output retire_t             result
);

  ctrl_t ctrl;
  word_t op_a;
  word_t rs2_val;
  word_t op_b;
  word_t alu_out;
  word_t link_pc;
  word_t jalr_sum;
  logic  cond;
  logic  is_link;

  // MX wins over WX, both over the value read in decode
  function automatic word_t bypass(input reg_addr_t idx, input word_t rf_val,
                                   input retire_t mem, input reg_write_t wb);
    if (idx == '0) begin
      return rf_val;
    end
    if (mem.reg_we && mem.rd == idx) begin
      return mem.rd_data;
    end
    if (wb.we && wb.rd == idx) begin
      return wb.data;
    end
    return rf_val;
  endfunction

  assign ctrl    = execute_entry.ctrl;
  assign op_a    = bypass(execute_entry.rs1, execute_entry.rs1_data, mem_entry, wb_write);
  assign rs2_val = bypass(execute_entry.rs2, execute_entry.rs2_data, mem_entry, wb_write);
  assign op_b    = ctrl.use_imm ? ctrl.imm : rs2_val;

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_SLL:    alu_out = op_a << op_b[4:0];
      ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   alu_out = word_t'(op_a < op_b);
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SRL:    alu_out = op_a >> op_b[4:0];
      ALU_SRA:    alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_OR:     alu_out = op_a | op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  // branches compare the two register operands, never the immediate
  always_comb begin
    case (ctrl.branch_f3)
      F3_BEQ:  cond = (op_a == rs2_val);
      F3_BNE:  cond = (op_a != rs2_val);
      F3_BLT:  cond = ($signed(op_a) < $signed(rs2_val));
      F3_BGE:  cond = ($signed(op_a) >= $signed(rs2_val));
      F3_BLTU: cond = (op_a < rs2_val);
      F3_BGEU: cond = (op_a >= rs2_val);
      default: cond = 1'b0;
    endcase
  end

  assign is_link  = ctrl.is_jal || ctrl.is_jalr;
  assign link_pc  = execute_entry.pc + PC_STEP;
  assign jalr_sum = op_a + ctrl.imm;

  assign redirect    = (ctrl.is_branch && cond) || is_link;
  assign redirect_pc = ctrl.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0}
                                    : execute_entry.pc + ctrl.imm;

  always_comb begin
    result.pc      = execute_entry.pc;
    result.insn    = execute_entry.insn;
    result.rd      = execute_entry.rd;
    result.rd_data = is_link ? link_pc : alu_out;
    // x0 writes die here so nothing downstream sees them
    result.reg_we  = ctrl.reg_we && (execute_entry.rd != '0);
    result.halt    = ctrl.is_halt;
    result.status  = execute_entry.status;
  end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import rv_isa_pkg::*, pipe_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire word_t     insn,
  input  wire            redirect,
  input  wire word_t     redirect_pc,
  output word_t          pc,
  output decode_entry_t  decode_entry
);

  word_t         pc_q;
  decode_entry_t dec_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q  <= '0;
      dec_q <= '{pc: '0, insn: '0, status: CYCLE_RESET};
    end else begin
      pc_q <= redirect ? redirect_pc : pc_q + PC_STEP;
      // the word fetched alongside a taken transfer is on the wrong path
      if (redirect) begin
        dec_q <= '{pc: '0, insn: '0, status: CYCLE_TAKEN_BRANCH};
      end else begin
        dec_q <= '{pc: pc_q, insn: insn, status: CYCLE_NO_STALL};
      end
    end
  end

  assign pc           = pc_q;
  assign decode_entry = dec_q;

  // catches a bad jump target computed in execute
  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rtl/retire_stage.sv
`timescale 1ns/1ps
`default_nettype none

module retire_stage import rv_isa_pkg::*, pipe_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire retire_t   result,
  output retire_t        mem_entry,
  output reg_write_t     wb_write,
  output logic           halt,
  output word_t          trace_pc,
  output word_t          trace_insn,
  output cycle_status_e  trace_status
);

  retire_t mem_q;
  retire_t wb_q;
  logic    halt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_q        <= '0;
      mem_q.status <= CYCLE_RESET;
      wb_q         <= '0;
      wb_q.status  <= CYCLE_RESET;
      halt_q       <= 1'b0;
    end else begin
      // memory stage only delays, no data port here
      mem_q  <= result;
      wb_q   <= mem_q;
      halt_q <= halt_q || wb_q.halt;
    end
  end

  assign mem_entry = mem_q;

  assign wb_write.we   = wb_q.reg_we;
  assign wb_write.rd   = wb_q.rd;
  assign wb_write.data = wb_q.rd_data;

  // high as ecall enters writeback, held from then on
  assign halt = halt_q || wb_q.halt;

  assign trace_pc     = wb_q.pc;
  assign trace_insn   = wb_q.insn;
  assign trace_status = wb_q.status;

  // every stage must tag what it sends down the pipe
  status_valid: assert property (@(posedge clk) disable iff (rst)
    wb_q.status != CYCLE_INVALID);

endmodule

`default_nettype wire

// File: rtl/riscv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_pipeline import rv_isa_pkg::*, pipe_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire word_t     insn,
  output word_t          pc,
  output logic           halt,
  output reg_write_t     reg_write,
  output word_t          trace_pc,
  output word_t          trace_insn,
  output cycle_status_e  trace_status
);

  decode_entry_t  decode_entry;
  execute_entry_t execute_entry;
  retire_t        result;
  retire_t        mem_entry;
  logic           redirect;
  word_t          redirect_pc;

  fetch_stage u_fetch (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .pc           (pc),
    .decode_entry (decode_entry)
  );

  decode_stage u_decode (
    .clk           (clk),
    .rst           (rst),
    .decode_entry  (decode_entry),
    .redirect      (redirect),
    .wb_write      (reg_write),
    .execute_entry (execute_entry)
  );

  // writeback port also feeds the WX bypass
  execute_stage u_execute (
    .execute_entry (execute_entry),
    .mem_entry     (mem_entry),
    .wb_write      (reg_write),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .result        (result)
  );

  retire_stage u_retire (
    .clk          (clk),
    .rst          (rst),
    .result       (result),
    .mem_entry    (mem_entry),
    .wb_write     (reg_write),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status)
  );

endmodule

`default_nettype wire

// File: sim/pipeline_vectors.txt
# P <word hex>: program word at the next address; H <pc hex>: pc of the ecall
# W <rd dec> <data hex>: expected register write, in retirement order
P 123450b7
P 67808113
P ffb00193
P 00310233
P 402202b3
P 00400313
P 006113b3
P 0062d433
P 4062d4b3
P 0062a533
P 0062b5b3
P 00714633
P 006666b3
P 0026f733
P ffc1a793
P ffc1b813
P fff14893
P 0ff0e913
P 0f017993
P 00819a13
P 01c1da93
P 4011db13
P 00110013
P 00f50463
P 7ff00b93
P 00f51463
P 0061c463
P 7ff00b93
P 0061d463
P 0061e463
P 0061f463
P 7ff00b93
P 00c00c6f
P 7ff00b93
P 7ff00b93
P 09800c93
P 004c8d67
P 7ff00b93
P 7ff00b93
P 018d0db3
P 00000073
W 1 12345000
W 2 12345678
W 3 fffffffb
W 4 12345673
W 5 fffffffb
W 6 00000004
W 7 23456780
W 8 0fffffff
W 9 ffffffff
W 10 00000001
W 11 00000000
W 12 317131f8
W 13 317131fc
W 14 10301078
W 15 00000001
W 16 00000001
W 17 edcba987
W 18 123450ff
W 19 00000070
W 20 fffffb00
W 21 0000000f
W 22 fffffffd
W 24 00000084
W 25 00000098
W 26 00000094
W 27 00000118
H 000000a0

// File: sim/tb_riscv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_pipeline import rv_isa_pkg::*, pipe_pkg::*; ();

  localparam int CLK_PERIOD      = 4;
  localparam int MEM_WORDS       = 256;
  localparam int MAX_WRITES      = 64;
  localparam int CYCLES_PER_WORD = 20;
  localparam int HOLD_CYCLES     = 4;

  logic          clk;
  logic          rst;
  word_t         insn;
  word_t         pc;
  logic          halt;
  reg_write_t    reg_write;
  word_t         trace_pc;
  word_t         trace_insn;
  cycle_status_e trace_status;

  word_t     prog [MEM_WORDS];
  reg_addr_t exp_rd [MAX_WRITES];
  word_t     exp_data [MAX_WRITES];
  // architectural state as seen at writeback
  word_t     shadow [NUM_REGS];
  int        n_prog;
  int        n_writes;
  word_t     halt_pc;
  logic      loaded;

  riscv_pipeline uut (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .pc           (pc),
    .halt         (halt),
    .reg_write    (reg_write),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // combinational instruction memory
  // words past the array read as zero
  assign insn = (pc[31:2] < MEM_WORDS) ? prog[pc[31:2]] : '0;

  task automatic stop_with_failure();
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      F3_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // next pc after a retired instruction by the ISA rules
  task automatic next_pc_of(input word_t ipc, input word_t iw, output word_t npc,
                            output logic taken);
    word_t imm_i;
    word_t imm_b;
    word_t imm_j;
    word_t rs1_val;
    word_t rs2_val;
    imm_i   = {{20{iw[31]}}, iw[31:20]};
    imm_b   = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
    imm_j   = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
    rs1_val = shadow[iw[19:15]];
    rs2_val = shadow[iw[24:20]];
    npc     = ipc + PC_STEP;
    taken   = 1'b0;
    case (iw[6:0])
      OP_JAL: begin
        npc   = ipc + imm_j;
        taken = 1'b1;
      end
      OP_JALR: begin
        npc   = (rs1_val + imm_i) & ~32'd1;
        taken = 1'b1;
      end
      OP_BRANCH: begin
        if (branch_taken(iw[14:12], rs1_val, rs2_val)) begin
          npc   = ipc + imm_b;
          taken = 1'b1;
        end
      end
      default: ;
    endcase
  endtask

  task automatic load_vectors();
    int              fd;
    int              code;
    logic [7:0]      tag;
    int              rd_num;
    word_t           value;
    logic [8*96-1:0] rest;
    fd = $fopen("sim/pipeline_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open sim/pipeline_vectors.txt");
      stop_with_failure();
    end
    n_prog   = 0;
    n_writes = 0;
    halt_pc  = '1;
    while ($fscanf(fd, " %c", tag) == 1) begin
      case (tag)
        "#": code = $fgets(rest, fd);
        "P": begin
          code = $fscanf(fd, "%h", value);
          if (code != 1 || n_prog >= MEM_WORDS) begin
            $display("bad or surplus program line in the vector file");
            stop_with_failure();
          end
          prog[n_prog] = value;
          n_prog++;
        end
        "W": begin
          code = $fscanf(fd, "%d %h", rd_num, value);
          if (code != 2 || n_writes >= MAX_WRITES) begin
            $display("bad or surplus register write line in the vector file");
            stop_with_failure();
          end
          exp_rd[n_writes]   = reg_addr_t'(rd_num);
          exp_data[n_writes] = value;
          n_writes++;
        end
        "H": begin
          code = $fscanf(fd, "%h", halt_pc);
          if (code != 1) begin
            $display("bad halt line in the vector file");
            stop_with_failure();
          end
        end
        default: begin
          $display("unknown line tag in the vector file");
          stop_with_failure();
        end
      endcase
    end
    $fclose(fd);
    if (n_prog == 0 || n_writes == 0) begin
      $display("vector file holds no program or no expected writes");
      stop_with_failure();
    end
  endtask

  task automatic verify_idle_outputs();
    check_value("trace_status", trace_status, CYCLE_RESET);
    check_value("trace_pc", trace_pc, '0);
    check_value("trace_insn", trace_insn, '0);
    check_value("reg_write.we", reg_write.we, 1'b0);
    check_value("halt", halt, 1'b0);
  endtask

  initial begin : main_seq
    word_t exp_pc;
    logic  taken;
    int    bubbles;
    int    w_idx;
    logic  halted;
    clk    = 1'b0;
    rst    = 1'b1;
    loaded = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      prog[i] = '0;
    end
    for (int i = 0; i < NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    load_vectors();
    loaded = 1'b1;

    repeat (4) begin
      @(posedge clk);
      #1;
      check_value("pc", pc, '0);
      verify_idle_outputs();
    end
    rst = 1'b0;
    // reset bubbles still draining toward writeback
    for (int k = 1; k <= 3; k++) begin
      @(posedge clk);
      #1;
      check_value("pc", pc, k * PC_STEP);
      verify_idle_outputs();
    end

    exp_pc  = '0;
    bubbles = 0;
    w_idx   = 0;
    halted  = 1'b0;
    while (!halted) begin
      @(posedge clk);
      #1;
      if (bubbles > 0) begin
        check_value("trace_status", trace_status, CYCLE_TAKEN_BRANCH);
        check_value("reg_write.we", reg_write.we, 1'b0);
        bubbles--;
      end else begin
        check_value("trace_status", trace_status, CYCLE_NO_STALL);
        check_value("trace_pc", trace_pc, exp_pc);
        check_value("trace_insn", trace_insn, prog[exp_pc[31:2]]);
        // shadow still holds the state before this instruction
        next_pc_of(exp_pc, prog[exp_pc[31:2]], exp_pc, taken);
        bubbles = taken ? 2 : 0;
        if (reg_write.we) begin
          if (w_idx >= n_writes) begin
            $display("register write to x%0d beyond the expected list", reg_write.rd);
            stop_with_failure();
          end
          if (reg_write.rd == '0) begin
            $display("a write to x0 reached writeback");
            stop_with_failure();
          end
          check_value("reg_write.rd", reg_write.rd, exp_rd[w_idx]);
          check_value("reg_write.data", reg_write.data, exp_data[w_idx]);
          shadow[exp_rd[w_idx]] = exp_data[w_idx];
          w_idx++;
        end
      end
      halted = halt;
    end
    check_value("trace_pc at halt", trace_pc, halt_pc);
    check_value("retired write count", w_idx, n_writes);

    // halt is sticky and nothing retires a write afterwards
    repeat (HOLD_CYCLES) begin
      @(posedge clk);
      #1;
      check_value("halt", halt, 1'b1);
      check_value("reg_write.we", reg_write.we, 1'b0);
    end
    $display("all tests passed");
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = n_prog * CYCLES_PER_WORD + 8 + HOLD_CYCLES;
    repeat (limit) @(posedge clk);
    $display("timeout, halt did not rise within %0d cycles", limit);
    stop_with_failure();
  end

endmodule

`default_nettype wire
